/* logger_defs.svh */
`ifndef LOGGER_DEFS_SVH
`define LOGGER_DEFS_SVH

// record buffer
`define LOG_DEPTH     16        // power of two
`define LOG_ADDR_W    4

// record fields
`define MEAS_W        12        // per meter channel
`define LOGIC_W       16        // analyzer pin word
`define CHK_W         6

//////////////////////////////
// dump framing

`define FRAME_BYTES   6
`define HDR_SAMPLE    8'h0A
`define HDR_LOGIC     8'h0C

// clk100 cycles per uart bit
`define CLKS_PER_BIT  8

`endif

/* logger_pkg.sv */
`include "logger_defs.svh"

package logger_pkg;

	// meter sample, kind 0
	typedef struct packed {
		logic [`MEAS_W-1:0]  volt;
		logic [`MEAS_W-1:0]  curr;
		logic [`CHK_W-1:0]   chk;
		logic                kind;
		logic                valid;
	} sample_rec_t;

	// analyzer event, kind 1
	typedef struct packed {
		logic [`LOGIC_W-1:0] pins;
		logic [7:0]          rsvd;     // always zero
		logic [`CHK_W-1:0]   chk;
		logic                kind;
		logic                valid;
	} logic_rec_t;

	// one stored word, kind/valid at bits 1/0 in both views
	typedef union packed {
		sample_rec_t smp;
		logic_rec_t  lgc;
	} log_rec_u;

	typedef logic [7:0] uart_byte_t;

endpackage

/* record_if.sv */
`timescale 1ns/1ps

interface record_if import logger_pkg::*; ();

	// write side
	logic     wr_en;
	log_rec_u wr_rec;
	logic     capture_end;          // level, high from session end to next start
	logic     full;

	// read side
	logic     empty;
	logic     rd_req;               // single cycle pulse
	log_rec_u rd_rec;
	logic     rd_valid;             // one cycle after rd_req

	modport producer (
		output wr_en, wr_rec, capture_end,
		input  full
	);

	modport buffer (
		input  wr_en, wr_rec, capture_end, rd_req,
		output full, empty, rd_rec, rd_valid
	);

	modport consumer (
		input  capture_end, empty, rd_rec, rd_valid,
		output rd_req
	);

endinterface

/* sample_packer.sv */
`timescale 1ns/1ps
`include "logger_defs.svh"

module sample_packer import logger_pkg::*; (
	input  logic               i_clk100,
	input  logic               i_rst_p,
	input  logic               i_start,
	input  logic               i_stop,
	input  logic               i_meas_valid,
	input  logic [`MEAS_W-1:0] i_meas_v,
	input  logic [`MEAS_W-1:0] i_meas_i,
	input  logic               i_logic_event,
	input  logic [`LOGIC_W-1:0] i_logic_data,
	output logic               o_capturing,
	record_if.producer         rec
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_CAP  = 2'd1;
	localparam logic [1:0] ST_END  = 2'd2;

	logic [1:0]            state;
	logic [`LOG_ADDR_W:0]  wr_cnt;      // records written this session
	logic                  last_wr;
	logic                  pend_vld;
	log_rec_u              pend_rec;
	log_rec_u              smp_rec, lgc_rec, rec_nxt;
	logic [7:0]            smp_sum, lgc_sum;
	logic                  wr_nxt, load_pend, take_pend;

	assign o_capturing = (state == ST_CAP);
	assign last_wr = rec.wr_en && (wr_cnt == (`LOG_ADDR_W+1)'(`LOG_DEPTH - 1));

	//////////////////////////////
	// record packing

	always_comb begin
		smp_sum = i_meas_v[11:4] + {i_meas_v[3:0], i_meas_i[11:8]} + i_meas_i[7:0];
		smp_rec.smp.volt  = i_meas_v;
		smp_rec.smp.curr  = i_meas_i;
		smp_rec.smp.chk   = smp_sum[`CHK_W-1:0];
		smp_rec.smp.kind  = 1'b0;
		smp_rec.smp.valid = 1'b1;

		lgc_sum = i_logic_data[15:8] + i_logic_data[7:0];
		lgc_rec.lgc.pins  = i_logic_data;
		lgc_rec.lgc.rsvd  = 8'h00;
		lgc_rec.lgc.chk   = lgc_sum[`CHK_W-1:0];
		lgc_rec.lgc.kind  = 1'b1;
		lgc_rec.lgc.valid = 1'b1;
	end

	// sample first, then pending event, then a fresh event
	always_comb begin
		wr_nxt    = 1'b0;
		rec_nxt   = smp_rec;
		load_pend = 1'b0;
		take_pend = 1'b0;
		if (state == ST_CAP && !i_stop && !last_wr && !rec.full) begin
			if (i_meas_valid) begin
				wr_nxt    = 1'b1;
				load_pend = i_logic_event && !pend_vld;    // park the event
			end else if (pend_vld) begin
				wr_nxt    = 1'b1;
				rec_nxt   = pend_rec;
				take_pend = 1'b1;                          // new event here is lost
			end else if (i_logic_event) begin
				wr_nxt    = 1'b1;
				rec_nxt   = lgc_rec;
			end
		end
	end

	//////////////////////////////
	// session control

	always_ff @(posedge i_clk100 or posedge i_rst_p) begin
		if (i_rst_p) begin
			state           <= ST_IDLE;
			wr_cnt          <= '0;
			pend_vld        <= 1'b0;
			rec.wr_en       <= 1'b0;
			rec.capture_end <= 1'b0;
		end else begin
			rec.wr_en <= wr_nxt;
			case (state)
				ST_IDLE, ST_END: begin
					if (i_start) begin
						state           <= ST_CAP;
						wr_cnt          <= '0;
						pend_vld        <= 1'b0;
						rec.capture_end <= 1'b0;    // buffer restarts empty
					end
				end
				ST_CAP: begin
					if (rec.wr_en)
						wr_cnt <= wr_cnt + 1'b1;
					if (i_stop || last_wr) begin
						state           <= ST_END;
						pend_vld        <= 1'b0;    // pending event discarded
						rec.capture_end <= 1'b1;
					end else if (load_pend) begin
						pend_vld <= 1'b1;
					end else if (take_pend) begin
						pend_vld <= 1'b0;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk100) begin
		rec.wr_rec <= rec_nxt;
		if (load_pend)
			pend_rec <= lgc_rec;
	end

	// the write that fills the buffer must be the last one
	a_no_wr_full: assert property (@(posedge i_clk100) disable iff (i_rst_p)
		!(rec.wr_en && rec.full));

endmodule

/* record_buffer.sv */
`timescale 1ns/1ps
`include "logger_defs.svh"

module record_buffer import logger_pkg::*; (
	input  logic     i_clk100,
	input  logic     i_rst_p,
	record_if.buffer rec
);

	log_rec_u               mem [`LOG_DEPTH];
	logic [`LOG_ADDR_W-1:0] wr_ptr, rd_ptr;
	logic [`LOG_ADDR_W:0]   count;
	logic                   end_q;
	logic                   new_session;

	// capture_end falling marks a fresh start
	assign new_session = end_q && !rec.capture_end;

	assign rec.full  = (count == (`LOG_ADDR_W+1)'(`LOG_DEPTH));
	assign rec.empty = (count == '0);

	always_ff @(posedge i_clk100 or posedge i_rst_p) begin
		if (i_rst_p) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			end_q        <= 1'b0;
			rec.rd_valid <= 1'b0;
		end else begin
			end_q        <= rec.capture_end;
			rec.rd_valid <= rec.rd_req;
			if (new_session) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count  <= '0;
			end else begin
				if (rec.wr_en)
					wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
				if (rec.rd_req)
					rd_ptr <= rd_ptr + 1'b1;
				case ({rec.wr_en, rec.rd_req})
					2'b10:   count <= count + 1'b1;
					2'b01:   count <= count - 1'b1;
					default: count <= count;
				endcase
			end
		end
	end

	// storage and registered read port
	always_ff @(posedge i_clk100) begin
		if (rec.wr_en)
			mem[wr_ptr] <= rec.wr_rec;
		if (rec.rd_req)
			rec.rd_rec <= mem[rd_ptr];
	end

	a_no_rd_empty: assert property (@(posedge i_clk100) disable iff (i_rst_p)
		!(rec.rd_req && rec.empty));

endmodule

/* dump_serializer.sv */
`timescale 1ns/1ps
`include "logger_defs.svh"

module dump_serializer import logger_pkg::*; (
	input  logic       i_clk100,
	input  logic       i_rst_p,
	record_if.consumer rec,
	input  logic       i_tx_busy,
	output logic       o_tx_start,
	output uart_byte_t o_tx_byte,
	output logic       o_done
);

	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_NEXT = 3'd1;   // fetch or finish
	localparam logic [2:0] ST_READ = 3'd2;
	localparam logic [2:0] ST_SEND = 3'd3;
	localparam logic [2:0] ST_DONE = 3'd4;

	logic [2:0] state;
	logic [2:0] byte_idx;
	log_rec_u   cur_rec;
	uart_byte_t frame_byte;
	logic       tx_free;

	// busy rises one cycle after start, so hold off that cycle too
	assign tx_free = !i_tx_busy && !o_tx_start;
	assign o_done  = (state == ST_DONE);

	//////////////////////////////
	// frame layout per record kind

	always_comb begin
		frame_byte = 8'h00;
		if (!cur_rec.smp.kind) begin
			case (byte_idx)
				3'd0:    frame_byte = `HDR_SAMPLE;
				3'd1:    frame_byte = {4'h0, cur_rec.smp.volt[11:8]};
				3'd2:    frame_byte = cur_rec.smp.volt[7:0];
				3'd3:    frame_byte = {4'h0, cur_rec.smp.curr[11:8]};
				3'd4:    frame_byte = cur_rec.smp.curr[7:0];
				default: frame_byte = {2'b00, cur_rec.smp.chk};
			endcase
		end else begin
			case (byte_idx)
				3'd0:    frame_byte = `HDR_LOGIC;
				3'd1:    frame_byte = cur_rec.lgc.pins[15:8];
				3'd2:    frame_byte = cur_rec.lgc.pins[7:0];
				3'd3:    frame_byte = cur_rec.lgc.rsvd;
				3'd4:    frame_byte = 8'h00;
				default: frame_byte = {2'b00, cur_rec.lgc.chk};
			endcase
		end
	end

	//////////////////////////////
	// dump sequencing

	always_ff @(posedge i_clk100 or posedge i_rst_p) begin
		if (i_rst_p) begin
			state      <= ST_IDLE;
			byte_idx   <= '0;
			rec.rd_req <= 1'b0;
			o_tx_start <= 1'b0;
		end else begin
			rec.rd_req <= 1'b0;
			o_tx_start <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (rec.capture_end)
						state <= ST_NEXT;
				end
				ST_NEXT: begin
					if (!rec.empty) begin
						rec.rd_req <= 1'b1;
						state      <= ST_READ;
					end else if (tx_free) begin
						state <= ST_DONE;       // last stop bit is out
					end
				end
				ST_READ: begin
					if (rec.rd_valid) begin
						byte_idx <= '0;
						state    <= ST_SEND;
					end
				end
				ST_SEND: begin
					if (tx_free) begin
						o_tx_start <= 1'b1;
						if (byte_idx == 3'(`FRAME_BYTES - 1))
							state <= ST_NEXT;   // prefetch during last byte
						else
							byte_idx <= byte_idx + 1'b1;
					end
				end
				ST_DONE: begin
					if (!rec.capture_end)
						state <= ST_IDLE;       // new session armed
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk100) begin
		if (rec.rd_valid)
			cur_rec <= rec.rd_rec;
		if (state == ST_SEND && tx_free)
			o_tx_byte <= frame_byte;
	end

	// every stored record was built valid by the packer
	a_rec_valid: assert property (@(posedge i_clk100) disable iff (i_rst_p)
		rec.rd_valid |-> rec.rd_rec.smp.valid);

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps
`include "logger_defs.svh"

module uart_tx import logger_pkg::*; (
	input  logic       i_clk100,
	input  logic       i_rst_p,
	input  logic       i_tx_start,
	input  uart_byte_t i_tx_byte,
	output logic       o_tx_busy,
	output logic       o_tx_serial
);

	localparam int CNT_W = $clog2(`CLKS_PER_BIT);

	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_idx;     // 0 start, 1..8 data, 9 stop
	uart_byte_t       tx_data;
	logic             bit_end;

	assign bit_end = (clk_cnt == CNT_W'(`CLKS_PER_BIT - 1));

	always_ff @(posedge i_clk100 or posedge i_rst_p) begin
		if (i_rst_p) begin
			o_tx_busy   <= 1'b0;
			o_tx_serial <= 1'b1;       // line idles high
			clk_cnt     <= '0;
			bit_idx     <= '0;
		end else if (!o_tx_busy) begin
			clk_cnt <= '0;
			bit_idx <= '0;
			if (i_tx_start) begin
				o_tx_busy   <= 1'b1;
				o_tx_serial <= 1'b0;   // start bit
			end
		end else if (bit_end) begin
			clk_cnt <= '0;
			bit_idx <= bit_idx + 1'b1;
			if (bit_idx == 4'd9) begin
				o_tx_busy <= 1'b0;     // stop bit done
			end else if (bit_idx == 4'd8) begin
				o_tx_serial <= 1'b1;
			end else begin
				o_tx_serial <= tx_data[bit_idx[2:0]];   // lsb first
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	always_ff @(posedge i_clk100) begin
		if (i_tx_start && !o_tx_busy)
			tx_data <= i_tx_byte;
	end

endmodule

/* logger_top.sv */
`timescale 1ns/1ps
`include "logger_defs.svh"

module logger_top import logger_pkg::*; (
	input  logic                clk100,
	input  logic                rst_p,
	input  logic                i_start,
	input  logic                i_stop,
	input  logic                i_meas_valid,
	input  logic [`MEAS_W-1:0]  i_meas_v,
	input  logic [`MEAS_W-1:0]  i_meas_i,
	input  logic                i_logic_event,
	input  logic [`LOGIC_W-1:0] i_logic_data,
	output logic                o_capturing,
	output logic                o_done,
	output logic                o_uart_tx
);

	logic       tx_start;
	logic       tx_busy;
	uart_byte_t tx_byte;

	record_if rec_if ();

	//////////////////////////////
	// capture path

	sample_packer u_packer (
		.i_clk100      (clk100),
		.i_rst_p       (rst_p),
		.i_start       (i_start),
		.i_stop        (i_stop),
		.i_meas_valid  (i_meas_valid),
		.i_meas_v      (i_meas_v),
		.i_meas_i      (i_meas_i),
		.i_logic_event (i_logic_event),
		.i_logic_data  (i_logic_data),
		.o_capturing   (o_capturing),
		.rec           (rec_if.producer)
	);

	record_buffer u_buffer (
		.i_clk100 (clk100),
		.i_rst_p  (rst_p),
		.rec      (rec_if.buffer)
	);

	//////////////////////////////
	// dump path

	dump_serializer u_dump (
		.i_clk100   (clk100),
		.i_rst_p    (rst_p),
		.rec        (rec_if.consumer),
		.i_tx_busy  (tx_busy),
		.o_tx_start (tx_start),
		.o_tx_byte  (tx_byte),
		.o_done     (o_done)
	);

	uart_tx u_uart_tx (
		.i_clk100    (clk100),
		.i_rst_p     (rst_p),
		.i_tx_start  (tx_start),
		.i_tx_byte   (tx_byte),
		.o_tx_busy   (tx_busy),
		.o_tx_serial (o_uart_tx)
	);

endmodule

/* tb_logger_top.sv */
`timescale 1ns/1ps
`include "logger_defs.svh"

module tb_logger_top import logger_pkg::*; ();

	localparam int BIT_NS   = `CLKS_PER_BIT * 20;   // one uart bit in ns
	localparam int IDLE_CYC = 10 * `CLKS_PER_BIT + 40;   // room for a whole byte
	localparam int N_EV     = 9;
	localparam int N_SESS   = 5;

	// one stimulus line repeated rep times
	typedef struct packed {
		logic [7:0]          gap;     // cycles since previous strobe
		logic [7:0]          rep;
		logic                smp;
		logic                lgc;
		logic                rnd;     // values from the generator
		logic [`MEAS_W-1:0]  v;
		logic [`MEAS_W-1:0]  i;
		logic [`LOGIC_W-1:0] pins;
	} ev_t;

	typedef struct packed {
		logic [7:0] first;
		logic [7:0] n_ev;
		logic       stop;
		logic [7:0] frames;           // expected dump length
	} sess_t;

	logic                clk100;
	logic                rst_p;
	logic                i_start;
	logic                i_stop;
	logic                i_meas_valid;
	logic [`MEAS_W-1:0]  i_meas_v;
	logic [`MEAS_W-1:0]  i_meas_i;
	logic                i_logic_event;
	logic [`LOGIC_W-1:0] i_logic_data;
	logic                o_capturing;
	logic                o_done;
	logic                o_uart_tx;

	ev_t        ev_tab [N_EV];
	sess_t      sess_tab [N_SESS];
	uart_byte_t rx_q [$];          // bytes seen on the line
	log_rec_u   exp_q [$];         // records the session should store
	log_rec_u   pend_rec;
	logic       pend_vld;
	logic [31:0] rng_state = 32'd6;
	longint     limit_ns = 0;
	int         err_byte = 0;
	int         err_rec = 0;
	int         err_flag = 0;
	int         err_other = 0;

	logger_top i_dut (
		.clk100        (clk100),
		.rst_p         (rst_p),
		.i_start       (i_start),
		.i_stop        (i_stop),
		.i_meas_valid  (i_meas_valid),
		.i_meas_v      (i_meas_v),
		.i_meas_i      (i_meas_i),
		.i_logic_event (i_logic_event),
		.i_logic_data  (i_logic_data),
		.o_capturing   (o_capturing),
		.o_done        (o_done),
		.o_uart_tx     (o_uart_tx)
	);

	always #10 clk100 = ~clk100;

	//////////////////////////////
	// reference model

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic ev_t mk_ev(input int gap, input int rep, input logic smp,
			input logic lgc, input logic rnd, input logic [11:0] v,
			input logic [11:0] i, input logic [15:0] pins);
		ev_t e;
		e.gap  = 8'(gap);
		e.rep  = 8'(rep);
		e.smp  = smp;
		e.lgc  = lgc;
		e.rnd  = rnd;
		e.v    = v;
		e.i    = i;
		e.pins = pins;
		return e;
	endfunction

	function automatic sess_t mk_sess(input int first, input int n_ev, input logic stop,
			input int frames);
		sess_t s;
		s.first  = 8'(first);
		s.n_ev   = 8'(n_ev);
		s.stop   = stop;
		s.frames = 8'(frames);
		return s;
	endfunction

	function automatic log_rec_u sample_rec(input logic [11:0] v, input logic [11:0] i);
		log_rec_u r;
		int       sum;
		sum = (v >> 4) + (((v & 15) << 4) | (i >> 8)) + (i & 255);    // three byte terms
		r.smp.volt  = v;
		r.smp.curr  = i;
		r.smp.chk   = 6'(sum % 64);
		r.smp.kind  = 1'b0;
		r.smp.valid = 1'b1;
		return r;
	endfunction

	function automatic log_rec_u logic_rec(input logic [15:0] p);
		log_rec_u r;
		int       sum;
		sum = (p >> 8) + (p & 255);
		r.lgc.pins  = p;
		r.lgc.rsvd  = 8'h00;
		r.lgc.chk   = 6'(sum % 64);
		r.lgc.kind  = 1'b1;
		r.lgc.valid = 1'b1;
		return r;
	endfunction

	// byte k of the six-byte frame with the header first
	function automatic uart_byte_t frame_byte(input log_rec_u r, input int k);
		logic [47:0] fr;
		if (r.smp.kind)
			fr = {`HDR_LOGIC, r.lgc.pins, r.lgc.rsvd, 8'h00, 2'b00, r.lgc.chk};
		else
			fr = {`HDR_SAMPLE, 4'h0, r.smp.volt, 4'h0, r.smp.curr, 2'b00, r.smp.chk};
		return fr[47-8*k -: 8];
	endfunction

	function automatic log_rec_u rebuild_rec(input logic [47:0] fr);
		log_rec_u r;
		if (fr[47:40] == `HDR_LOGIC) begin
			r.lgc.pins  = fr[39:24];
			r.lgc.rsvd  = fr[23:16];
			r.lgc.chk   = fr[5:0];
			r.lgc.kind  = 1'b1;
		end else begin
			r.smp.volt  = {fr[35:32], fr[31:24]};
			r.smp.curr  = {fr[19:16], fr[15:8]};
			r.smp.chk   = fr[5:0];
			r.smp.kind  = 1'b0;
		end
		r.smp.valid = 1'b1;
		return r;
	endfunction

	// one clock of capture where the sample wins and one event may wait
	task automatic model_cycle(input logic smp, input logic lgc, input logic stop,
			input logic [11:0] v, input logic [11:0] i, input logic [15:0] p);
		if (stop || exp_q.size() >= `LOG_DEPTH) begin
			pend_vld = 1'b0;
		end else if (smp) begin
			exp_q.push_back(sample_rec(v, i));
			if (lgc && !pend_vld) begin
				pend_vld = 1'b1;
				pend_rec = logic_rec(p);
			end
		end else if (pend_vld) begin
			exp_q.push_back(pend_rec);     // a new event now is lost
			pend_vld = 1'b0;
		end else if (lgc) begin
			exp_q.push_back(logic_rec(p));
		end
	endtask

	//////////////////////////////
	// checks

	task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
		if (act !== exp) begin
			err_byte++;
			$display("Fail %0t ns %s exp %h act %h", $time, name, exp, act);
		end
	endtask

	task automatic check_rec(input string name, input log_rec_u exp, input log_rec_u act);
		if (act !== exp) begin
			err_rec++;
			$display("Fail %0t ns %s exp %h act %h", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			err_flag++;
			$display("Fail %0t ns %s exp %b act %b", $time, name, exp, act);
		end
	endtask

	// uart receiver sampling at mid-bit
	always begin : uart_monitor
		uart_byte_t b;
		int         k;
		@(negedge o_uart_tx);
		#(BIT_NS / 2);
		if (o_uart_tx !== 1'b0) begin
			err_other++;
			$display("start bit on o_uart_tx did not hold low at %0t ns", $time);
		end else begin
			for (k = 0; k < 8; k++) begin
				#(BIT_NS);
				b[k] = o_uart_tx;    // lsb first
			end
			#(BIT_NS);
			if (o_uart_tx !== 1'b1) begin
				err_other++;
				$display("stop bit missing on o_uart_tx at %0t ns", $time);
			end
			rx_q.push_back(b);
		end
	end

	//////////////////////////////
	// stimulus

	task automatic drive_strobes(input logic smp, input logic lgc, input logic [11:0] v,
			input logic [11:0] i, input logic [15:0] p);
		i_meas_valid  = smp;
		i_logic_event = lgc;
		i_meas_v      = v;
		i_meas_i      = i;
		i_logic_data  = p;
	endtask

	task automatic build_table();
		ev_tab[0] = mk_ev(1, 1, 1, 0, 0, 12'h123, 12'h456, 16'h0000);
		ev_tab[1] = mk_ev(3, 1, 0, 1, 0, 12'h000, 12'h000, 16'hBEEF);
		ev_tab[2] = mk_ev(2, 1, 1, 1, 0, 12'hABC, 12'hDEF, 16'h1234);   // event parked
		ev_tab[3] = mk_ev(1, 1, 1, 1, 1, 12'h000, 12'h000, 16'h0000);   // event dropped
		ev_tab[4] = mk_ev(1, 1, 0, 1, 0, 12'h000, 12'h000, 16'h5678);   // dropped too
		ev_tab[5] = mk_ev(3, 1, 1, 0, 1, 12'h000, 12'h000, 16'h0000);
		ev_tab[6] = mk_ev(2, 10, 1, 1, 1, 12'h000, 12'h000, 16'h0000);  // overruns depth
		ev_tab[7] = mk_ev(1, 2, 1, 0, 1, 12'h000, 12'h000, 16'h0000);
		ev_tab[8] = mk_ev(4, 1, 0, 1, 1, 12'h000, 12'h000, 16'h0000);
		sess_tab[0] = mk_sess(0, 1, 1, 1);
		sess_tab[1] = mk_sess(1, 1, 1, 1);
		sess_tab[2] = mk_sess(2, 4, 1, 4);
		sess_tab[3] = mk_sess(6, 1, 0, `LOG_DEPTH);
		sess_tab[4] = mk_sess(7, 2, 1, 3);
	endtask

	task automatic idle_check();
		int k;
		for (k = 0; k < IDLE_CYC; k++) begin
			@(negedge clk100);
			drive_strobes(k == 5, 1'b0, 12'h321, 12'h654, 16'h0000);
			check_flag("o_capturing", 1'b0, o_capturing);
			check_flag("o_done", 1'b0, o_done);
			check_flag("o_uart_tx", 1'b1, o_uart_tx);
		end
		if (rx_q.size() != 0) begin
			err_other++;
			$display("bytes were sent on o_uart_tx before any start");
		end
	endtask

	task automatic compare_dump(input int s);
		int          n;
		int          k;
		int          j;
		logic [47:0] fr;
		uart_byte_t  b;
		n = exp_q.size();
		if (n != sess_tab[s].frames) begin
			err_other++;
			$display("session %0d builds %0d records but its table line lists %0d",
				s, n, sess_tab[s].frames);
		end
		if (rx_q.size() != n * `FRAME_BYTES) begin
			err_other++;
			$display("Fail %0t ns rx byte count exp %0d act %0d", $time,
				n * `FRAME_BYTES, rx_q.size());
		end
		for (k = 0; k < n && rx_q.size() >= `FRAME_BYTES; k++) begin
			fr = '0;
			for (j = 0; j < `FRAME_BYTES; j++) begin
				b  = rx_q.pop_front();
				check_byte($sformatf("o_uart_tx frame %0d byte %0d", k, j),
					frame_byte(exp_q[k], j), b);
				fr = {fr[39:0], b};
			end
			check_rec($sformatf("o_uart_tx record %0d", k), exp_q[k], rebuild_rec(fr));
		end
		rx_q.delete();
	endtask

	task automatic run_session(input int s);
		int            e;
		int            r;
		logic [11:0]   v;
		logic [11:0]   ii;
		logic [15:0]   p;
		ev_t           ev;
		exp_q.delete();
		pend_vld = 1'b0;
		@(negedge clk100);
		i_start = 1'b1;
		@(negedge clk100);
		i_start = 1'b0;
		check_flag("o_capturing", 1'b1, o_capturing);
		for (e = sess_tab[s].first; e < sess_tab[s].first + sess_tab[s].n_ev; e++) begin
			ev = ev_tab[e];
			for (r = 0; r < ev.rep; r++) begin
				repeat (int'(ev.gap) - 1) begin
					@(negedge clk100);
					drive_strobes(1'b0, 1'b0, i_meas_v, i_meas_i, i_logic_data);
					model_cycle(1'b0, 1'b0, 1'b0, 12'h0, 12'h0, 16'h0);
				end
				v  = ev.v;
				ii = ev.i;
				p  = ev.pins;
				if (ev.rnd) begin
					rng_state = xorshift32(rng_state);
					v         = rng_state[11:0];
					ii        = rng_state[23:12];
					rng_state = xorshift32(rng_state);
					p         = rng_state[15:0];
				end
				@(negedge clk100);
				drive_strobes(ev.smp, ev.lgc, v, ii, p);
				model_cycle(ev.smp, ev.lgc, 1'b0, v, ii, p);
			end
		end
		@(negedge clk100);
		drive_strobes(1'b0, 1'b0, i_meas_v, i_meas_i, i_logic_data);
		i_stop = sess_tab[s].stop;
		model_cycle(1'b0, 1'b0, sess_tab[s].stop, 12'h0, 12'h0, 16'h0);
		check_flag("o_done", 1'b0, o_done);
		@(negedge clk100);
		i_stop = 1'b0;
		check_flag("o_capturing", 1'b0, o_capturing);    // stopped or full
		while (o_done !== 1'b1)
			@(negedge clk100);
		compare_dump(s);
	endtask

	// watchdog armed once the table length is known
	initial begin : watchdog
		wait (limit_ns > 0);
		#(limit_ns);
		$display("timeout after %0d ns, a dump never completed", limit_ns);
		$display("TEST FAIL");
		$finish;
	end

	initial begin : main
		int     s;
		int     e;
		longint cyc;
		longint nbytes;
		clk100  = 1'b0;
		rst_p   = 1'b1;
		i_start = 1'b0;
		i_stop  = 1'b0;
		drive_strobes(1'b0, 1'b0, 12'h000, 12'h000, 16'h0000);
		build_table();
		cyc    = 10 + IDLE_CYC;
		nbytes = 0;
		for (s = 0; s < N_SESS; s++) begin
			cyc    = cyc + 30;
			nbytes = nbytes + sess_tab[s].frames * `FRAME_BYTES;
			for (e = sess_tab[s].first; e < sess_tab[s].first + sess_tab[s].n_ev; e++)
				cyc = cyc + ev_tab[e].gap * ev_tab[e].rep;
		end
		limit_ns = 2 * (nbytes * 10 * `CLKS_PER_BIT * 20 + cyc * 20);
		repeat (10) @(negedge clk100);
		rst_p = 1'b0;
		idle_check();
		for (s = 0; s < N_SESS; s++)
			run_session(s);
		$display("errors: byte %0d record %0d flag %0d other %0d",
			err_byte, err_rec, err_flag, err_other);
		if (err_byte + err_rec + err_flag + err_other == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* all.f */
+incdir+.
logger_pkg.sv
record_if.sv
sample_packer.sv
record_buffer.sv
dump_serializer.sv
uart_tx.sv
logger_top.sv
tb_logger_top.sv

/* Bender.yml */
package:
  name: logger

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - logger_pkg.sv
      - record_if.sv
      - sample_packer.sv
      - record_buffer.sv
      - dump_serializer.sv
      - uart_tx.sv
      - logger_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_logger_top.sv
